//--- vlog.f
+incdir+.
pkt_mem_pkg.sv
packet_ram.sv
buf_rotator.sv
buffer_crossbar.sv
read_size_adapter.sv
packet_mem.sv
packet_mem_assertions.sv
packet_mem_tb.sv

//--- Makefile
# Verilator build and run of the packet memory testbench
VERILATOR ?= verilator
TOP       ?= packet_mem_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SOURCES   ?= pkt_mem_consts.svh pkt_mem_pkg.sv packet_ram.sv buf_rotator.sv \
	buffer_crossbar.sv read_size_adapter.sv packet_mem.sv \
	packet_mem_assertions.sv packet_mem_tb.sv

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the run prints the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

//--- packet_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module packet_mem_tb;
	import pkt_mem_pkg::*;

	localparam int NUM_ROWS = 9;
	localparam int TIMEOUT  = 5000; // Cycles per wait

	// Name, words, verdict, hold verdict until all buffers full, sweep every offset
	string row_name [NUM_ROWS] = '{"short_acc", "sweep_acc", "small_rej", "hold_rej",
		"after_rej", "pair_acc", "hold_acc", "reuse_acc", "tail_rej"};
	int row_words [NUM_ROWS] = '{4, 6, 3, 8, 5, 2, 4, 10, 4};
	bit row_acc   [NUM_ROWS] = '{1, 1, 0, 0, 1, 1, 1, 1, 0};
	bit row_hold  [NUM_ROWS] = '{0, 0, 0, 1, 0, 0, 1, 0, 0};
	bit row_sweep [NUM_ROWS] = '{0, 1, 0, 0, 0, 0, 0, 0, 0};
	// CPU reads as byte address and size where -1 marks an empty slot
	int row_rd_addr [NUM_ROWS][4] = '{'{0, 3, 6, 15}, '{-1, -1, -1, -1}, '{1, 7, 10, -1},
		'{29, 13, 0, 28}, '{16, 11, -1, -1}, '{4, 3, -1, -1}, '{12, 9, -1, -1},
		'{37, 38, 22, -1}, '{5, -1, -1, -1}};
	int row_rd_sz [NUM_ROWS][4] = '{'{2, 1, 3, 0}, '{0, 0, 0, 0}, '{0, 2, 1, 0},
		'{1, 2, 0, 3}, '{2, 1, 0, 0}, '{2, 2, 0, 0}, '{3, 0, 0, 0},
		'{1, 1, 2, 0}, '{2, 0, 0, 0}};

	logic        clk;
	logic        arst_n;
	word_addr_t  snooper_wr_addr;
	word_t       snooper_wr_data;
	logic        snooper_wr_en;
	logic        snooper_done;
	logic        ready_for_snooper;
	byte_addr_t  cpu_byte_rd_addr;
	xfer_size_t  transfer_sz;
	logic        cpu_rd_en;
	logic        cpu_acc;
	logic        cpu_rej;
	logic        ready_for_cpu;
	word_t       cpu_rd_data;
	pkt_len_t    len_to_cpu;
	logic        cpu_rd_valid;
	dword_addr_t forwarder_rd_addr;
	logic        forwarder_rd_en;
	logic        forwarder_done;
	logic        ready_for_forwarder;
	dword_t      forwarder_rd_data;
	pkt_len_t    len_to_forwarder;
	logic        fwd_rd_valid;

	word_t ref_q [$];          // Every packet word in table order
	int    snoop_count   = 0;  // Packets ended by the snooper
	int    verdict_count = 0;  // Packets judged by the CPU

	packet_mem i_dut (.*);

	bind buf_rotator packet_mem_assertions i_assertions (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_dword(input string name, input dword_t exp, input dword_t act);
		if (act !== exp)
			report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_len(input string name, input pkt_len_t exp, input pkt_len_t act);
		if (act !== exp)
			report_failure($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
	endtask

	function automatic int row_base(input int row);
		int base = 0;
		for (int r = 0; r < row; r++) begin
			base += row_words[r];
		end
		return base;
	endfunction

	function automatic int size_bytes(input int sz);
		return (sz == 0) ? 1 : (sz == 1) ? 2 : 4; // Size 3 reads 4 bytes too
	endfunction

	// Byte k sits in lane k mod 4 of word k/4
	function automatic word_t expected_read(input int row, input int addr, input int sz);
		word_t exp;
		int    k;
		exp = '0;
		for (int j = 0; j < size_bytes(sz); j++) begin
			k = addr + j;
			exp[8*j +: 8] = ref_q[row_base(row) + k/4][8*(k%4) +: 8];
		end
		return exp;
	endfunction

	// Agent 0 snooper, 1 CPU, 2 forwarder
	task automatic wait_ready(input int agent, input string what);
		int cycles = 0;
		@(posedge clk);
		while (!((agent == 0) ? ready_for_snooper :
			(agent == 1) ? ready_for_cpu : ready_for_forwarder)) begin
			cycles++;
			if (cycles > TIMEOUT)
				report_failure({"timeout waiting for ", what});
			@(posedge clk);
		end
	endtask

	task automatic drive_snooper();
		word_t data;
		for (int r = 0; r < NUM_ROWS; r++) begin
			wait_ready(0, {row_name[r], " snooper ready"});
			if (r == 0 && (ready_for_cpu || ready_for_forwarder))
				report_failure("CPU or forwarder ready before any packet was written");
			for (int w = 0; w < row_words[r]; w++) begin
				data = $urandom;
				ref_q.push_back(data);
				snooper_wr_en   <= 1'b1;
				snooper_wr_addr <= word_addr_t'(w);
				snooper_wr_data <= data;
				@(posedge clk);
			end
			snooper_wr_en <= 1'b0;
			snooper_done  <= 1'b1;
			snoop_count++;
			@(posedge clk);
			snooper_done <= 1'b0;
		end
	endtask

	// Result due exactly one cycle after the strobe
	task automatic cpu_read(input int r, input int addr, input int sz);
		cpu_rd_en        <= 1'b1;
		cpu_byte_rd_addr <= byte_addr_t'(addr);
		transfer_sz      <= xfer_size_t'(sz);
		@(posedge clk);
		cpu_rd_en <= 1'b0;
		@(posedge clk);
		if (!cpu_rd_valid)
			report_failure($sformatf("%s: cpu_rd_valid low one cycle after read", row_name[r]));
		check_word($sformatf("%s cpu read addr %0d size %0d", row_name[r], addr, sz),
			expected_read(r, addr, sz), cpu_rd_data);
	endtask

	// Verdict held back until the snooper has filled the other two buffers
	task automatic hold_verdict(input int r);
		int cycles = 0;
		while (snoop_count < r + 3) begin
			cycles++;
			if (cycles > TIMEOUT)
				report_failure("timeout waiting for all three buffers to fill");
			@(posedge clk);
		end
		repeat (3) @(posedge clk);
		for (int i = 0; i < 8; i++) begin
			if (ready_for_snooper)
				report_failure("snooper ready while all three buffers are full");
			@(posedge clk);
		end
	endtask

	task automatic drive_cpu();
		for (int r = 0; r < NUM_ROWS; r++) begin
			wait_ready(1, {row_name[r], " CPU ready"});
			if (snoop_count <= r)
				report_failure("CPU ready before the snooper ended the packet");
			check_len({row_name[r], " len_to_cpu"}, pkt_len_t'(row_words[r]), len_to_cpu);
			if (row_sweep[r]) begin
				for (int sz = 0; sz < 3; sz++) begin
					for (int a = 0; a + size_bytes(sz) <= 4*row_words[r]; a++) begin
						cpu_read(r, a, sz);
					end
				end
			end else begin
				for (int i = 0; i < 4; i++) begin
					if (row_rd_addr[r][i] >= 0)
						cpu_read(r, row_rd_addr[r][i], row_rd_sz[r][i]);
				end
			end
			if (row_hold[r])
				hold_verdict(r);
			cpu_acc <= row_acc[r];
			cpu_rej <= !row_acc[r];
			verdict_count++;
			@(posedge clk);
			cpu_acc <= 1'b0;
			cpu_rej <= 1'b0;
		end
	endtask

	// Accepted rows only in table order
	task automatic drive_forwarder();
		int base;
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (!row_acc[r])
				continue;
			base = row_base(r);
			wait_ready(2, {row_name[r], " forwarder ready"});
			if (verdict_count <= r)
				report_failure("forwarder ready before the CPU accepted the packet");
			check_len({row_name[r], " len_to_forwarder"}, pkt_len_t'(row_words[r]),
				len_to_forwarder);
			for (int k = 0; 2*k < row_words[r]; k++) begin
				forwarder_rd_en   <= 1'b1;
				forwarder_rd_addr <= dword_addr_t'(k);
				@(posedge clk);
				forwarder_rd_en <= 1'b0;
				@(posedge clk);
				if (!fwd_rd_valid)
					report_failure({row_name[r], ": fwd_rd_valid low one cycle after read"});
				if (2*k + 1 < row_words[r])
					check_dword($sformatf("%s fwd read %0d", row_name[r], k),
						{ref_q[base + 2*k + 1], ref_q[base + 2*k]}, forwarder_rd_data);
				else // Upper word of an odd tail lies past the packet
					check_word($sformatf("%s fwd read %0d", row_name[r], k),
						ref_q[base + 2*k], forwarder_rd_data[31:0]);
			end
			forwarder_done <= 1'b1;
			@(posedge clk);
			forwarder_done <= 1'b0;
		end
	endtask

	initial begin
		void'($urandom(32'h1848));
		arst_n            <= 1'b0;
		snooper_wr_addr   <= '0;
		snooper_wr_data   <= '0;
		snooper_wr_en     <= 1'b0;
		snooper_done      <= 1'b0;
		cpu_byte_rd_addr  <= '0;
		transfer_sz       <= '0;
		cpu_rd_en         <= 1'b0;
		cpu_acc           <= 1'b0;
		cpu_rej           <= 1'b0;
		forwarder_rd_addr <= '0;
		forwarder_rd_en   <= 1'b0;
		forwarder_done    <= 1'b0;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		fork
			drive_snooper();
			drive_cpu();
			drive_forwarder();
		join
		// Rejected tail never reaches the forwarder
		for (int i = 0; i < 20; i++) begin
			@(posedge clk);
			if (ready_for_forwarder)
				report_failure("forwarder given a buffer that was never accepted");
		end
		wait_ready(0, "snooper ready once every buffer is free");
		if (i_dut.i_rotator.i_assertions.fail_count == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			report_failure("an ownership assertion on the rotator failed");
		end
	end

endmodule

`default_nettype wire

//--- packet_mem_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module packet_mem_assertions (
	input wire                       clk,
	input wire                       arst_n,
	input wire                       snooper_done,
	input wire                       cpu_acc,
	input wire                       cpu_rej,
	input wire                       forwarder_done,
	input wire pkt_mem_pkg::buf_id_t sn_buf,
	input wire pkt_mem_pkg::buf_id_t cpu_buf,
	input wire pkt_mem_pkg::buf_id_t fwd_buf
);

	int fail_count = 0; // Failed assertions so far

	// Each buffer has at most one owner
	a_one_owner: assert property (@(posedge clk) disable iff (!arst_n)
		(sn_buf == '0 || (sn_buf != cpu_buf && sn_buf != fwd_buf)) &&
		(cpu_buf == '0 || cpu_buf != fwd_buf))
		else begin
			$error("two agents own the same buffer");
			fail_count++;
		end

	// Ownership gone on the clock after an end strobe
	a_snoop_release: assert property (@(posedge clk) disable iff (!arst_n)
		snooper_done && sn_buf != '0 |=> sn_buf == '0)
		else begin
			$error("snooper still owns a buffer after done");
			fail_count++;
		end

	a_cpu_release: assert property (@(posedge clk) disable iff (!arst_n)
		(cpu_acc || cpu_rej) && cpu_buf != '0 |=> cpu_buf == '0)
		else begin
			$error("CPU still owns a buffer after its verdict");
			fail_count++;
		end

	a_fwd_release: assert property (@(posedge clk) disable iff (!arst_n)
		forwarder_done && fwd_buf != '0 |=> fwd_buf == '0)
		else begin
			$error("forwarder still owns a buffer after done");
			fail_count++;
		end

	// No owner at all while in reset
	a_reset_ids: assert property (@(posedge clk)
		!arst_n |-> sn_buf == '0 && cpu_buf == '0 && fwd_buf == '0)
		else begin
			$error("buffer id not zero during reset");
			fail_count++;
		end

endmodule

`default_nettype wire

//--- packet_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_mem_consts.svh"

module packet_mem (
	input  wire                           clk,
	input  wire                           arst_n,

	// Snooper
	input  wire pkt_mem_pkg::word_addr_t  snooper_wr_addr,
	input  wire pkt_mem_pkg::word_t       snooper_wr_data,
	input  wire                           snooper_wr_en,
	input  wire                           snooper_done,      // 1-cycle strobe
	output logic                          ready_for_snooper,

	// CPU
	input  wire pkt_mem_pkg::byte_addr_t  cpu_byte_rd_addr,
	input  wire pkt_mem_pkg::xfer_size_t  transfer_sz,
	input  wire                           cpu_rd_en,
	input  wire                           cpu_acc,
	input  wire                           cpu_rej,
	output logic                          ready_for_cpu,
	output pkt_mem_pkg::word_t            cpu_rd_data,
	output pkt_mem_pkg::pkt_len_t         len_to_cpu,
	output logic                          cpu_rd_valid,

	// Forwarder
	input  wire pkt_mem_pkg::dword_addr_t forwarder_rd_addr,
	input  wire                           forwarder_rd_en,
	input  wire                           forwarder_done,
	output logic                          ready_for_forwarder,
	output pkt_mem_pkg::dword_t           forwarder_rd_data,
	output pkt_mem_pkg::pkt_len_t         len_to_forwarder,
	output logic                          fwd_rd_valid
);
	import pkt_mem_pkg::*;

	buf_id_t                  sn_buf;
	buf_id_t                  cpu_buf;
	buf_id_t                  fwd_buf;
	logic [`PKT_NUM_BUFS-1:0] len_clr;
	word_addr_t               cpu_word_addr;
	dword_t                   cpu_pair;
	word_addr_t               ram_addr [`PKT_NUM_BUFS];   // Index 0 ping, 1 pang, 2 pung
	word_t                    ram_wr_data [`PKT_NUM_BUFS];
	logic                     ram_wr_en [`PKT_NUM_BUFS];
	logic                     ram_rd_en [`PKT_NUM_BUFS];
	dword_t                   ram_rd_data [`PKT_NUM_BUFS];
	pkt_len_t                 ram_len [`PKT_NUM_BUFS];

	// An agent is ready whenever it owns a buffer
	assign ready_for_snooper   = (sn_buf != '0);
	assign ready_for_cpu       = (cpu_buf != '0);
	assign ready_for_forwarder = (fwd_buf != '0);

	buf_rotator i_rotator (
		.clk            (clk),
		.arst_n         (arst_n),
		.snooper_done   (snooper_done),
		.cpu_acc        (cpu_acc),
		.cpu_rej        (cpu_rej),
		.forwarder_done (forwarder_done),
		.sn_buf         (sn_buf),
		.cpu_buf        (cpu_buf),
		.fwd_buf        (fwd_buf),
		.len_clr        (len_clr)
	);

	// Byte reads become word pair reads
	read_size_adapter i_cpu_adapter (
		.clk       (clk),
		.arst_n    (arst_n),
		.byte_addr (cpu_byte_rd_addr),
		.size      (transfer_sz),
		.word_addr (cpu_word_addr),
		.pair      (cpu_pair),
		.rd_data   (cpu_rd_data)
	);

	buffer_crossbar i_xbar (
		.clk          (clk),
		.arst_n       (arst_n),
		.sn_buf       (sn_buf),
		.cpu_buf      (cpu_buf),
		.fwd_buf      (fwd_buf),
		.snoop_addr   (snooper_wr_addr),
		.snoop_data   (snooper_wr_data),
		.snoop_wr_en  (snooper_wr_en),
		.cpu_addr     (cpu_word_addr),
		.cpu_rd_en    (cpu_rd_en),
		.fwd_addr     (forwarder_rd_addr),
		.fwd_rd_en    (forwarder_rd_en),
		.ram_rd_data  (ram_rd_data),
		.ram_len      (ram_len),
		.ram_addr     (ram_addr),
		.ram_wr_data  (ram_wr_data),
		.ram_wr_en    (ram_wr_en),
		.ram_rd_en    (ram_rd_en),
		.cpu_pair     (cpu_pair),
		.fwd_data     (forwarder_rd_data),
		.cpu_len      (len_to_cpu),
		.fwd_len      (len_to_forwarder),
		.cpu_rd_valid (cpu_rd_valid),
		.fwd_rd_valid (fwd_rd_valid)
	);

	packet_ram ping (
		.clk     (clk),
		.arst_n  (arst_n),
		.addr    (ram_addr[0]),
		.wr_data (ram_wr_data[0]),
		.wr_en   (ram_wr_en[0]),
		.rd_en   (ram_rd_en[0]),
		.len_clr (len_clr[0]),
		.rd_data (ram_rd_data[0]),
		.len     (ram_len[0])
	);

	packet_ram pang (
		.clk     (clk),
		.arst_n  (arst_n),
		.addr    (ram_addr[1]),
		.wr_data (ram_wr_data[1]),
		.wr_en   (ram_wr_en[1]),
		.rd_en   (ram_rd_en[1]),
		.len_clr (len_clr[1]),
		.rd_data (ram_rd_data[1]),
		.len     (ram_len[1])
	);

	packet_ram pung (
		.clk     (clk),
		.arst_n  (arst_n),
		.addr    (ram_addr[2]),
		.wr_data (ram_wr_data[2]),
		.wr_en   (ram_wr_en[2]),
		.rd_en   (ram_rd_en[2]),
		.len_clr (len_clr[2]),
		.rd_data (ram_rd_data[2]),
		.len     (ram_len[2])
	);

endmodule

`default_nettype wire

//--- read_size_adapter.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_mem_consts.svh"

module read_size_adapter (
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire pkt_mem_pkg::byte_addr_t byte_addr,
	input  wire pkt_mem_pkg::xfer_size_t size,
	output pkt_mem_pkg::word_addr_t      word_addr,
	input  wire pkt_mem_pkg::dword_t     pair,      // Words at word_addr and word_addr+1
	output pkt_mem_pkg::word_t           rd_data    // Zero padded on the left
);
	import pkt_mem_pkg::*;

	logic [1:0] offset_q;  // Byte lane of the read in flight
	xfer_size_t size_q;
	dword_t     shifted;

	// Word holding the first byte, the next word covers boundary crossings
	assign word_addr = byte_addr[`PKT_ADDR_W+1:2];

	// Follows the RAM read register by one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			offset_q <= '0;
			size_q   <= '0;
		end else begin
			offset_q <= byte_addr[1:0];
			size_q   <= size;
		end
	end

	// Little endian, first byte lands in bits 7:0
	assign shifted = pair >> {offset_q, 3'b000};

	always_comb begin
		case (size_q)
			2'd0:    rd_data = {24'h0, shifted[7:0]};   // 1 byte
			2'd1:    rd_data = {16'h0, shifted[15:0]};  // 2 bytes
			default: rd_data = shifted[`PKT_DATA_W-1:0]; // 4 bytes, 3 too
		endcase
	end

endmodule

`default_nettype wire

//--- buffer_crossbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_mem_consts.svh"

module buffer_crossbar (
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire pkt_mem_pkg::buf_id_t    sn_buf,
	input  wire pkt_mem_pkg::buf_id_t    cpu_buf,
	input  wire pkt_mem_pkg::buf_id_t    fwd_buf,
	input  wire pkt_mem_pkg::word_addr_t snoop_addr,
	input  wire pkt_mem_pkg::word_t      snoop_data,
	input  wire                          snoop_wr_en,
	input  wire pkt_mem_pkg::word_addr_t cpu_addr,
	input  wire                          cpu_rd_en,
	input  wire pkt_mem_pkg::dword_addr_t fwd_addr,
	input  wire                          fwd_rd_en,
	input  wire pkt_mem_pkg::dword_t     ram_rd_data [`PKT_NUM_BUFS],
	input  wire pkt_mem_pkg::pkt_len_t   ram_len [`PKT_NUM_BUFS],
	output pkt_mem_pkg::word_addr_t      ram_addr [`PKT_NUM_BUFS],
	output pkt_mem_pkg::word_t           ram_wr_data [`PKT_NUM_BUFS],
	output logic                         ram_wr_en [`PKT_NUM_BUFS],
	output logic                         ram_rd_en [`PKT_NUM_BUFS],
	output pkt_mem_pkg::dword_t          cpu_pair,      // Raw pair, adapter picks bytes
	output pkt_mem_pkg::dword_t          fwd_data,
	output pkt_mem_pkg::pkt_len_t        cpu_len,
	output pkt_mem_pkg::pkt_len_t        fwd_len,
	output logic                         cpu_rd_valid,
	output logic                         fwd_rd_valid
);
	import pkt_mem_pkg::*;

	word_addr_t fwd_word_addr;
	buf_id_t    cpu_sel_q;     // Buffer of the read in flight
	buf_id_t    fwd_sel_q;

	// 64-bit index times two
	assign fwd_word_addr = {fwd_addr, 1'b0};

	// Request steering, ids are never shared so at most one match per RAM
	always_comb begin
		for (int i = 0; i < `PKT_NUM_BUFS; i++) begin
			ram_addr[i]    = '0;
			ram_wr_data[i] = snoop_data; // Only the snooper writes
			ram_wr_en[i]   = 1'b0;
			ram_rd_en[i]   = 1'b0;
			if (sn_buf == buf_id_t'(i + 1)) begin
				ram_addr[i]  = snoop_addr;
				ram_wr_en[i] = snoop_wr_en;
			end
			if (cpu_buf == buf_id_t'(i + 1)) begin
				ram_addr[i]  = cpu_addr;
				ram_rd_en[i] = cpu_rd_en;
			end
			if (fwd_buf == buf_id_t'(i + 1)) begin
				ram_addr[i]  = fwd_word_addr;
				ram_rd_en[i] = fwd_rd_en;
			end
		end
	end

	// Selects delayed to line up with the RAM output register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cpu_sel_q    <= '0;
			fwd_sel_q    <= '0;
			cpu_rd_valid <= 1'b0;
			fwd_rd_valid <= 1'b0;
		end else begin
			cpu_sel_q    <= cpu_buf;
			fwd_sel_q    <= fwd_buf;
			cpu_rd_valid <= cpu_rd_en && (cpu_buf != '0); // Ignored without ready
			fwd_rd_valid <= fwd_rd_en && (fwd_buf != '0);
		end
	end

	// Return path, length follows current ownership and data the delayed select
	always_comb begin
		cpu_pair = '0;
		fwd_data = '0;
		cpu_len  = '0;
		fwd_len  = '0;
		for (int i = 0; i < `PKT_NUM_BUFS; i++) begin
			if (cpu_sel_q == buf_id_t'(i + 1)) cpu_pair = ram_rd_data[i];
			if (fwd_sel_q == buf_id_t'(i + 1)) fwd_data = ram_rd_data[i];
			if (cpu_buf == buf_id_t'(i + 1))   cpu_len  = ram_len[i];
			if (fwd_buf == buf_id_t'(i + 1))   fwd_len  = ram_len[i];
		end
	end

endmodule

`default_nettype wire

//--- buf_rotator.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_mem_consts.svh"

module buf_rotator (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire                        snooper_done,   // 1-cycle strobes from the agents
	input  wire                        cpu_acc,
	input  wire                        cpu_rej,
	input  wire                        forwarder_done,
	output pkt_mem_pkg::buf_id_t       sn_buf,
	output pkt_mem_pkg::buf_id_t       cpu_buf,
	output pkt_mem_pkg::buf_id_t       fwd_buf,
	output logic [`PKT_NUM_BUFS-1:0]   len_clr         // One bit per buffer
);
	import pkt_mem_pkg::*;

	buf_state_e                state [`PKT_NUM_BUFS];
	buf_state_e                state_nxt [`PKT_NUM_BUFS];
	logic [1:0]                snoop_ptr;
	logic [1:0]                cpu_ptr;
	logic [1:0]                fwd_ptr;
	logic [1:0]                snoop_nxt;
	logic [1:0]                cpu_nxt;
	logic [1:0]                fwd_nxt;
	logic [`PKT_NUM_BUFS-1:0]  skip_fwd;      // Rejected, forwarder must step past
	logic [`PKT_NUM_BUFS-1:0]  skip_nxt;
	logic [`PKT_NUM_BUFS-1:0]  clr_nxt;

	// Ping, pang, pung, ping again
	function automatic logic [1:0] ring_next(input logic [1:0] p);
		return (p == 2'(`PKT_NUM_BUFS - 1)) ? 2'd0 : p + 2'd1;
	endfunction

	function automatic buf_id_t to_id(input logic [1:0] p);
		return p + 2'd1; // Id 0 is kept for no buffer
	endfunction

	// Each agent only touches states no other agent acts on, so no conflicts
	always_comb begin
		state_nxt = state;
		snoop_nxt = snoop_ptr;
		cpu_nxt   = cpu_ptr;
		fwd_nxt   = fwd_ptr;
		skip_nxt  = skip_fwd;
		clr_nxt   = '0;

		// Snooper side, a marked buffer waits until the forwarder has passed it
		if (state[snoop_ptr] == BUF_FREE && !skip_fwd[snoop_ptr]) begin
			state_nxt[snoop_ptr] = BUF_FILLING;
		end else if (state[snoop_ptr] == BUF_FILLING && snooper_done) begin
			state_nxt[snoop_ptr] = BUF_FILLED;
			snoop_nxt            = ring_next(snoop_ptr);
		end

		// CPU side
		if (state[cpu_ptr] == BUF_FILLED) begin
			state_nxt[cpu_ptr] = BUF_INSPECT;
		end else if (state[cpu_ptr] == BUF_INSPECT && cpu_acc) begin
			state_nxt[cpu_ptr] = BUF_ACCEPTED;
			cpu_nxt            = ring_next(cpu_ptr);
		end else if (state[cpu_ptr] == BUF_INSPECT && cpu_rej) begin
			state_nxt[cpu_ptr] = BUF_FREE; // Straight back to the snooper
			skip_nxt[cpu_ptr]  = 1'b1;
			clr_nxt[cpu_ptr]   = 1'b1;
			cpu_nxt            = ring_next(cpu_ptr);
		end

		// Forwarder side
		if (state[fwd_ptr] == BUF_ACCEPTED) begin
			state_nxt[fwd_ptr] = BUF_SENDING;
		end else if (state[fwd_ptr] == BUF_SENDING && forwarder_done) begin
			state_nxt[fwd_ptr] = BUF_FREE;
			clr_nxt[fwd_ptr]   = 1'b1;
			fwd_nxt            = ring_next(fwd_ptr);
		end else if (state[fwd_ptr] == BUF_FREE && skip_fwd[fwd_ptr]) begin
			skip_nxt[fwd_ptr] = 1'b0; // Rejected packet, never shown to forwarder
			fwd_nxt           = ring_next(fwd_ptr);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= '{default: BUF_FREE};
			snoop_ptr <= '0;
			cpu_ptr   <= '0;
			fwd_ptr   <= '0;
			skip_fwd  <= '0;
			sn_buf    <= '0;
			cpu_buf   <= '0;
			fwd_buf   <= '0;
			len_clr   <= '0;
		end else begin
			state     <= state_nxt;
			snoop_ptr <= snoop_nxt;
			cpu_ptr   <= cpu_nxt;
			fwd_ptr   <= fwd_nxt;
			skip_fwd  <= skip_nxt;
			// Ids follow the new state, so ready drops on the clock after a strobe
			sn_buf    <= (state_nxt[snoop_nxt] == BUF_FILLING) ? to_id(snoop_nxt) : '0;
			cpu_buf   <= (state_nxt[cpu_nxt] == BUF_INSPECT) ? to_id(cpu_nxt) : '0;
			fwd_buf   <= (state_nxt[fwd_nxt] == BUF_SENDING) ? to_id(fwd_nxt) : '0;
			len_clr   <= clr_nxt;
		end
	end

endmodule

`default_nettype wire

//--- packet_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_mem_consts.svh"

module packet_ram (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire pkt_mem_pkg::word_addr_t addr,
	input  wire pkt_mem_pkg::word_t wr_data,
	input  wire                     wr_en,
	input  wire                     rd_en,
	input  wire                     len_clr,  // Buffer handed back to the snooper
	output pkt_mem_pkg::dword_t     rd_data,  // Words addr and addr+1
	output pkt_mem_pkg::pkt_len_t   len
);
	import pkt_mem_pkg::*;

	word_t      mem [2**`PKT_ADDR_W];
	word_addr_t addr_hi;

	// Second word of the pair, wraps at the buffer end
	assign addr_hi = addr + 1'b1;

	// Single address bus, only one agent owns the buffer at a time
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[addr] <= wr_data;
		end
		if (rd_en) begin
			rd_data <= {mem[addr_hi], mem[addr]}; // Lower address in low half
		end
	end

	// Length counts writes, snooper writes from word 0 upwards
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			len <= '0;
		end else if (len_clr) begin
			len <= '0;
		end else if (wr_en) begin
			len <= len + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- pkt_mem_pkg.sv
`default_nettype none

`include "pkt_mem_consts.svh"

package pkt_mem_pkg;

	typedef logic [`PKT_DATA_W-1:0]   word_t;       // One packet word
	typedef logic [2*`PKT_DATA_W-1:0] dword_t;      // Word pair, lower address in low half
	typedef logic [`PKT_ADDR_W-1:0]   word_addr_t;  // Word index in a buffer
	typedef logic [`PKT_ADDR_W+1:0]   byte_addr_t;  // CPU byte address
	typedef logic [`PKT_ADDR_W-2:0]   dword_addr_t; // Forwarder 64-bit index
	typedef logic [1:0]               xfer_size_t;  // 0 = 1B, 1 = 2B, 2 and 3 = 4B
	typedef logic [`PKT_LEN_W-1:0]    pkt_len_t;    // Length in words

	// 0 means no buffer, then ping, pang, pung
	typedef logic [1:0] buf_id_t;

	// Life of one buffer around the ring
	typedef enum logic [2:0] {
		BUF_FREE,     // Waiting for the snooper
		BUF_FILLING,  // Snooper owns it
		BUF_FILLED,   // Waiting for the CPU
		BUF_INSPECT,  // CPU owns it
		BUF_ACCEPTED, // Waiting for the forwarder
		BUF_SENDING   // Forwarder owns it
	} buf_state_e;

endpackage

`default_nettype wire

//--- pkt_mem_consts.svh
`ifndef PKT_MEM_CONSTS_SVH
`define PKT_MEM_CONSTS_SVH

// Word address width of one packet buffer, 1024 words
`define PKT_ADDR_W 10

// Packet RAM word width
`define PKT_DATA_W 32

// Packet length counter width, in words
`define PKT_LEN_W 32

// Ring of ping, pang and pung
`define PKT_NUM_BUFS 3

`endif
